//--- hw/axi_xbar_pkg.sv
// AXI4-lite crossbar definitions
package axi_xbar_pkg;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES  = 5;
	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;

	typedef logic [ADDR_W-1:0]              addr_t;
	typedef logic [DATA_W-1:0]              data_t;
	typedef logic [DATA_W/8-1:0]            strb_t;    // One strobe per byte lane
	typedef logic [2:0]                     prot_t;
	typedef logic [$clog2(NUM_MASTERS)-1:0] mst_idx_t;
	typedef logic [$clog2(NUM_SLAVES)-1:0]  slv_idx_t;

	// Address map, index 0 first
	// A slave matches when (addr & ~mask) == use
	localparam addr_t SLV_MASK [NUM_SLAVES] = '{
		32'h0000_03FF,
		32'h0000_0001,
		32'h0000_0001,
		32'h0000_000F,
		32'h0000_0000
	};

	localparam addr_t SLV_USE [NUM_SLAVES] = '{
		32'h0000_0000,    // Low 1 KiB block
		32'h0000_0400,
		32'h0000_0408,
		32'h0000_0410,
		32'h0400_0000     // Single word far up
	};

	// Per-path arbiter states
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

endpackage

//--- hw/txn_grant_if.sv
// Arbiter to router grant link
`timescale 1ns/10ps

interface txn_grant_if;
	import axi_xbar_pkg::*;

	logic [NUM_MASTERS-1:0] req;    // One request line per master
	logic                   done;   // Response handshake of the granted master
	logic                   busy;
	mst_idx_t               grant;

	// Arbiter side
	modport arb (input req, input done, output busy, output grant);

	// Router side
	modport route (output req, output done, input busy, input grant);

endinterface

//--- hw/slave_addr_decode.sv
// Slave address decoder
`timescale 1ns/10ps

module slave_addr_decode (
	input  axi_xbar_pkg::addr_t    addr_i,
	output logic                   hit_o,
	output axi_xbar_pkg::slv_idx_t slave_o
);
	import axi_xbar_pkg::*;

	logic [NUM_SLAVES-1:0] match;

	// Mask/use compare per map entry
	always_comb begin
		for (int i = 0; i < NUM_SLAVES; i++) begin
			match[i] = ((addr_i & ~SLV_MASK[i]) == SLV_USE[i]);
		end
	end

	// Priority encode, walked from the top so the lowest match is the last write
	always_comb begin
		hit_o   = 1'b0;
		slave_o = '0;
		for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_o   = 1'b1;
				slave_o = slv_idx_t'(i);
			end
		end
	end

endmodule

//--- hw/master_arbiter.sv
// Round-robin master arbiter
`timescale 1ns/10ps

module master_arbiter (
	input logic      CLK,
	input logic      RST,
	txn_grant_if.arb gnt
);
	import axi_xbar_pkg::*;

	arb_state_e state_q;
	mst_idx_t   ptr_q;     // Master looked at while idle
	mst_idx_t   grant_q;

	// Next master in turn, wrapping after the last one
	function automatic mst_idx_t next_master(input mst_idx_t m);
		if (int'(m) == NUM_MASTERS - 1) begin
			return '0;
		end
		return m + 1'b1;
	endfunction

	always_ff @(posedge CLK) begin
		if (!RST) begin
			state_q <= ARB_IDLE;
			ptr_q   <= '0;
			grant_q <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (gnt.req[ptr_q]) begin
						state_q <= ARB_BUSY;
						grant_q <= ptr_q;
					end else begin
						ptr_q <= next_master(ptr_q);   // Nobody here, move on
					end
				end
				ARB_BUSY: begin
					if (gnt.done) begin
						state_q <= ARB_IDLE;
						ptr_q   <= next_master(grant_q);   // Fairness
					end
				end
				default: state_q <= ARB_IDLE;
			endcase
		end
	end

	assign gnt.busy  = (state_q == ARB_BUSY);
	assign gnt.grant = grant_q;

	// Owner may not change in the middle of a transaction
	a_grant_stable: assert property (@(posedge CLK) disable iff (!RST)
		gnt.busy && !gnt.done |=> gnt.busy && $stable(gnt.grant));

	// Router only reports completion for a granted transaction
	a_no_idle_done: assert property (@(posedge CLK) disable iff (!RST)
		!gnt.busy |-> !gnt.done);

endmodule

//--- hw/write_router.sv
// Write channel router
`timescale 1ns/10ps

module write_router (
	input  logic                                                   CLK,
	input  logic                                                   RST,
	txn_grant_if.route                                             gnt,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_awvalid_i,
	input  axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_awaddr_i,
	input  axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_awprot_i,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_wvalid_i,
	input  axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_wdata_i,
	input  axi_xbar_pkg::strb_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_wstrb_i,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_bready_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_awready_o,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_wready_o,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_bvalid_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_awready_i,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_wready_i,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_bvalid_i,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_awvalid_o,
	output axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_awaddr_o,
	output axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_awprot_o,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_wvalid_o,
	output axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_wdata_o,
	output axi_xbar_pkg::strb_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_wstrb_o,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_bready_o
);
	import axi_xbar_pkg::*;

	logic     hit;
	slv_idx_t slv;
	logic     done;

	// Address or data pending counts as a write request
	assign gnt.req  = m_awvalid_i | m_wvalid_i;
	assign gnt.done = done;

	slave_addr_decode u_dec (
		.addr_i  (m_awaddr_i[gnt.grant]),
		.hit_o   (hit),
		.slave_o (slv)
	);

	always_comb begin
		s_awvalid_o = '0;
		s_awaddr_o  = '0;
		s_awprot_o  = '0;
		s_wvalid_o  = '0;
		s_wdata_o   = '0;
		s_wstrb_o   = '0;
		s_bready_o  = '0;
		m_awready_o = '0;
		m_wready_o  = '0;
		m_bvalid_o  = '0;
		done        = 1'b0;
		if (gnt.busy && hit) begin
			// Forward path, granted master to decoded slave
			s_awvalid_o[slv] = m_awvalid_i[gnt.grant];
			s_awaddr_o[slv]  = m_awaddr_i[gnt.grant];
			s_awprot_o[slv]  = m_awprot_i[gnt.grant];
			s_wvalid_o[slv]  = m_wvalid_i[gnt.grant];
			s_wdata_o[slv]   = m_wdata_i[gnt.grant];
			s_wstrb_o[slv]   = m_wstrb_i[gnt.grant];
			s_bready_o[slv]  = m_bready_i[gnt.grant];
			// Return path
			m_awready_o[gnt.grant] = s_awready_i[slv];
			m_wready_o[gnt.grant]  = s_wready_i[slv];
			m_bvalid_o[gnt.grant]  = s_bvalid_i[slv];
			done = m_bready_i[gnt.grant] & s_bvalid_i[slv];   // B handshake ends it
		end
	end

	// Granted master must stay inside the address map
	a_wr_hit: assert property (@(posedge CLK) disable iff (!RST) gnt.busy |-> hit);

endmodule

//--- hw/read_router.sv
// Read channel router
`timescale 1ns/10ps

module read_router (
	input  logic                                                   CLK,
	input  logic                                                   RST,
	txn_grant_if.route                                             gnt,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_arvalid_i,
	input  axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_araddr_i,
	input  axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_arprot_i,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_rready_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_arready_o,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_rvalid_o,
	output axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_rdata_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_arready_i,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_rvalid_i,
	input  axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_rdata_i,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_arvalid_o,
	output axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_araddr_o,
	output axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_arprot_o,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_rready_o
);
	import axi_xbar_pkg::*;

	logic     hit;
	slv_idx_t slv;
	logic     done;

	assign gnt.req  = m_arvalid_i;
	assign gnt.done = done;

	slave_addr_decode u_dec (
		.addr_i  (m_araddr_i[gnt.grant]),
		.hit_o   (hit),
		.slave_o (slv)
	);

	always_comb begin
		s_arvalid_o = '0;
		s_araddr_o  = '0;
		s_arprot_o  = '0;
		s_rready_o  = '0;
		m_arready_o = '0;
		m_rvalid_o  = '0;
		m_rdata_o   = '0;
		done        = 1'b0;
		if (gnt.busy && hit) begin
			s_arvalid_o[slv] = m_arvalid_i[gnt.grant];
			s_araddr_o[slv]  = m_araddr_i[gnt.grant];
			s_arprot_o[slv]  = m_arprot_i[gnt.grant];
			s_rready_o[slv]  = m_rready_i[gnt.grant];
			// Read data back to the owner only
			m_arready_o[gnt.grant] = s_arready_i[slv];
			m_rvalid_o[gnt.grant]  = s_rvalid_i[slv];
			m_rdata_o[gnt.grant]   = s_rdata_i[slv];
			done = m_rready_i[gnt.grant] & s_rvalid_i[slv];
		end
	end

	// Unmapped reads have no error path
	a_rd_hit: assert property (@(posedge CLK) disable iff (!RST) gnt.busy |-> hit);

endmodule

//--- hw/axi_lite_xbar.sv
// AXI4-lite interconnect top
`timescale 1ns/10ps

module axi_lite_xbar (
	input  logic                                                   CLK,
	input  logic                                                   RST,
	// Master ports
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_awvalid_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_awready_o,
	input  axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_awaddr_i,
	input  axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_awprot_i,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_wvalid_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_wready_o,
	input  axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_wdata_i,
	input  axi_xbar_pkg::strb_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_wstrb_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_bvalid_o,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_bready_i,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_arvalid_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_arready_o,
	input  axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_araddr_i,
	input  axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_arprot_i,
	output logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_rvalid_o,
	input  logic [axi_xbar_pkg::NUM_MASTERS-1:0]                   m_rready_i,
	output axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_MASTERS-1:0]    m_rdata_o,
	// Slave ports
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_awvalid_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_awready_i,
	output axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_awaddr_o,
	output axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_awprot_o,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_wvalid_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_wready_i,
	output axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_wdata_o,
	output axi_xbar_pkg::strb_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_wstrb_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_bvalid_i,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_bready_o,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_arvalid_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_arready_i,
	output axi_xbar_pkg::addr_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_araddr_o,
	output axi_xbar_pkg::prot_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_arprot_o,
	input  logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_rvalid_i,
	output logic [axi_xbar_pkg::NUM_SLAVES-1:0]                    s_rready_o,
	input  axi_xbar_pkg::data_t [axi_xbar_pkg::NUM_SLAVES-1:0]     s_rdata_i
);

	// Independent read and write paths
	txn_grant_if wr_grant ();
	txn_grant_if rd_grant ();

	master_arbiter u_wr_arb (.CLK(CLK), .RST(RST), .gnt(wr_grant.arb));
	master_arbiter u_rd_arb (.CLK(CLK), .RST(RST), .gnt(rd_grant.arb));

	write_router u_wr_route (
		.CLK         (CLK),
		.RST         (RST),
		.gnt         (wr_grant.route),
		.m_awvalid_i (m_awvalid_i),
		.m_awaddr_i  (m_awaddr_i),
		.m_awprot_i  (m_awprot_i),
		.m_wvalid_i  (m_wvalid_i),
		.m_wdata_i   (m_wdata_i),
		.m_wstrb_i   (m_wstrb_i),
		.m_bready_i  (m_bready_i),
		.m_awready_o (m_awready_o),
		.m_wready_o  (m_wready_o),
		.m_bvalid_o  (m_bvalid_o),
		.s_awready_i (s_awready_i),
		.s_wready_i  (s_wready_i),
		.s_bvalid_i  (s_bvalid_i),
		.s_awvalid_o (s_awvalid_o),
		.s_awaddr_o  (s_awaddr_o),
		.s_awprot_o  (s_awprot_o),
		.s_wvalid_o  (s_wvalid_o),
		.s_wdata_o   (s_wdata_o),
		.s_wstrb_o   (s_wstrb_o),
		.s_bready_o  (s_bready_o)
	);

	read_router u_rd_route (
		.CLK         (CLK),
		.RST         (RST),
		.gnt         (rd_grant.route),
		.m_arvalid_i (m_arvalid_i),
		.m_araddr_i  (m_araddr_i),
		.m_arprot_i  (m_arprot_i),
		.m_rready_i  (m_rready_i),
		.m_arready_o (m_arready_o),
		.m_rvalid_o  (m_rvalid_o),
		.m_rdata_o   (m_rdata_o),
		.s_arready_i (s_arready_i),
		.s_rvalid_i  (s_rvalid_i),
		.s_rdata_i   (s_rdata_i),
		.s_arvalid_o (s_arvalid_o),
		.s_araddr_o  (s_araddr_o),
		.s_arprot_o  (s_arprot_o),
		.s_rready_o  (s_rready_o)
	);

endmodule

//--- bench/tb_axi_lite_xbar.sv
// AXI4-lite crossbar testbench
`timescale 1ns/10ps

module tb_axi_lite_xbar;
	import axi_xbar_pkg::*;

	localparam int NUM_TESTS    = 5;
	localparam int RESET_CYCLES = 5;

	logic CLK, RST;
	logic  [NUM_MASTERS-1:0] m_awvalid_i, m_awready_o, m_wvalid_i, m_wready_o, m_bvalid_o;
	logic  [NUM_MASTERS-1:0] m_bready_i, m_arvalid_i, m_arready_o, m_rvalid_o, m_rready_i;
	addr_t [NUM_MASTERS-1:0] m_awaddr_i, m_araddr_i;
	prot_t [NUM_MASTERS-1:0] m_awprot_i, m_arprot_i;
	data_t [NUM_MASTERS-1:0] m_wdata_i, m_rdata_o;
	strb_t [NUM_MASTERS-1:0] m_wstrb_i;
	logic  [NUM_SLAVES-1:0]  s_awvalid_o, s_awready_i, s_wvalid_o, s_wready_i, s_bvalid_i;
	logic  [NUM_SLAVES-1:0]  s_bready_o, s_arvalid_o, s_arready_i, s_rvalid_i, s_rready_o;
	addr_t [NUM_SLAVES-1:0]  s_awaddr_o, s_araddr_o;
	prot_t [NUM_SLAVES-1:0]  s_awprot_o, s_arprot_o;
	data_t [NUM_SLAVES-1:0]  s_wdata_o, s_rdata_i;
	strb_t [NUM_SLAVES-1:0]  s_wstrb_o;

	logic  [NUM_SLAVES-1:0]  b_next, r_next;
	data_t [NUM_SLAVES-1:0]  rdata_next;
	logic  [NUM_MASTERS-1:0] wr_pend, rd_pend;    // Transaction issued and not yet answered
	logic  [31:0]            lfsr, d, st, p;
	logic  [63:0]            got;
	addr_t                   addr;
	addr_t                   fa [8];
	int                      errors, err0, aw_seen, ar_seen, hm;
	int                      wr_order[$];
	int                      rd_order[$];

	axi_lite_xbar dut (.*);

	// Address map rule, lowest slave first
	function automatic int expected_slave(input addr_t a);
		if ((a & ~32'h3FF) == 32'h0) return 0;
		if ((a & ~32'h1) == 32'h400) return 1;
		if ((a & ~32'h1) == 32'h408) return 2;
		if ((a & ~32'hF) == 32'h410) return 3;
		if (a == 32'h0400_0000) return 4;
		return -1;
	endfunction

	function automatic data_t expected_rdata(input addr_t a);
		return {8'(expected_slave(a)), a[23:0]};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);    // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Random address inside one slave window
	task automatic draw_addr(input int s, output addr_t v);
		logic [31:0] bits;
		draw_bits(32, bits);
		v = SLV_USE[s] | (bits & SLV_MASK[s]);
	endtask

	task automatic report_mismatch(input string sig, input logic [63:0] g, input logic [63:0] e);
		$display("Mismatch at %0t: %s is %0h, expected %0h", $time, sig, g, e);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input int n, input string name);
		$display("Test %0d %s finished with %0d errors", n, name, errors - err0);
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic do_write(input int m, input addr_t a, input data_t wd, input strb_t ws,
			input prot_t wp);
		wr_pend[m]     = 1'b1;
		m_awaddr_i[m]  = a;
		m_awprot_i[m]  = wp;
		m_wdata_i[m]   = wd;
		m_wstrb_i[m]   = ws;
		m_bready_i[m]  = 1'b1;
		m_awvalid_i[m] = 1'b1;
		m_wvalid_i[m]  = 1'b1;
		@(negedge CLK);
		while (!m_awready_o[m]) @(negedge CLK);
		// Slaves accept data together with the address
		if (!m_wready_o[m]) begin
			report_mismatch($sformatf("m_wready_o[%0d]", m), 64'(m_wready_o[m]), 64'd1);
		end
		@(posedge CLK);
		#1;
		m_awvalid_i[m] = 1'b0;
		m_wvalid_i[m]  = 1'b0;
		@(negedge CLK);
		while (!m_bvalid_o[m]) @(negedge CLK);
		@(posedge CLK);
		#1;
		wr_pend[m] = 1'b0;
	endtask

	task automatic do_read(input int m, input addr_t a, input prot_t rp, input int hold);
		rd_pend[m]     = 1'b1;
		m_araddr_i[m]  = a;
		m_arprot_i[m]  = rp;
		m_rready_i[m]  = (hold == 0);
		m_arvalid_i[m] = 1'b1;
		@(negedge CLK);
		while (!m_arready_o[m]) @(negedge CLK);
		@(posedge CLK);
		#1;
		m_arvalid_i[m] = 1'b0;
		if (hold > 0) begin
			repeat (hold) @(negedge CLK);
			if (!m_rvalid_o[m]) report_error("read response dropped while rready was low");
			@(posedge CLK);
			#1;
			m_rready_i[m] = 1'b1;
		end
		@(negedge CLK);
		while (!(m_rvalid_o[m] && m_rready_i[m])) @(negedge CLK);
		@(posedge CLK);
		#1;
		rd_pend[m] = 1'b0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Watchdog, 200 cycles per test on top of reset
	initial begin
		#((NUM_TESTS * 200 + RESET_CYCLES) * 10);
		$display("Watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

	// Slave models answer one cycle after the address handshake
	always begin
		@(negedge CLK);
		b_next     = (s_bvalid_i & ~s_bready_o) | (s_awvalid_o & s_awready_i);
		r_next     = (s_rvalid_i & ~s_rready_o) | (s_arvalid_o & s_arready_i);
		rdata_next = s_rdata_i;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (s_arvalid_o[s] && s_arready_i[s]) begin
				rdata_next[s] = {8'(s), s_araddr_o[s][23:0]};
			end
		end
		@(posedge CLK);
		#1;
		s_bvalid_i = RST ? b_next : '0;
		s_rvalid_i = RST ? r_next : '0;
		s_rdata_i  = rdata_next;
	end

	// Both sides sampled mid-cycle, where all outputs are settled
	always @(negedge CLK) begin
		if (RST) begin
			if ($countones(s_awvalid_o) > 1 || $countones(s_arvalid_o) > 1) begin
				report_error("address valid reached more than one slave");
			end
			for (int s = 0; s < NUM_SLAVES; s++) begin
				if (s_awvalid_o[s] && s_awready_i[s]) begin
					aw_seen++;
					hm = -1;
					for (int m = 0; m < NUM_MASTERS; m++) begin
						if (wr_pend[m] && m_awvalid_i[m] && m_awaddr_i[m] == s_awaddr_o[s]) begin
							hm = m;
						end
					end
					if (expected_slave(s_awaddr_o[s]) != s) begin
						report_mismatch("write slave index", 64'(s),
							64'(expected_slave(s_awaddr_o[s])));
					end
					if (hm < 0) begin
						report_error($sformatf("write at slave %0d matches no issuing master", s));
					end else if ({s_wvalid_o[s], s_wdata_o[s], s_wstrb_o[s], s_awprot_o[s]} !=
							{1'b1, m_wdata_i[hm], m_wstrb_i[hm], m_awprot_i[hm]}) begin
						report_mismatch($sformatf("s_wvalid/wdata/wstrb/awprot[%0d]", s),
							64'({s_wvalid_o[s], s_wdata_o[s], s_wstrb_o[s], s_awprot_o[s]}),
							64'({1'b1, m_wdata_i[hm], m_wstrb_i[hm], m_awprot_i[hm]}));
					end
				end
				if (s_arvalid_o[s] && s_arready_i[s]) begin
					ar_seen++;
					hm = -1;
					for (int m = 0; m < NUM_MASTERS; m++) begin
						if (rd_pend[m] && m_arvalid_i[m] && m_araddr_i[m] == s_araddr_o[s]) begin
							hm = m;
						end
					end
					if (expected_slave(s_araddr_o[s]) != s) begin
						report_mismatch("read slave index", 64'(s),
							64'(expected_slave(s_araddr_o[s])));
					end
					if (hm < 0) begin
						report_error($sformatf("read at slave %0d matches no issuing master", s));
					end else if (s_arprot_o[s] != m_arprot_i[hm]) begin
						report_mismatch($sformatf("s_arprot_o[%0d]", s), 64'(s_arprot_o[s]),
							64'(m_arprot_i[hm]));
					end
				end
			end
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if ((m_bvalid_o[m] && !wr_pend[m]) || (m_rvalid_o[m] && !rd_pend[m])) begin
					report_error($sformatf("response reached master %0d with nothing issued", m));
				end
				if (m_rvalid_o[m] && m_rdata_o[m] != expected_rdata(m_araddr_i[m])) begin
					report_mismatch($sformatf("m_rdata_o[%0d]", m), 64'(m_rdata_o[m]),
						64'(expected_rdata(m_araddr_i[m])));
				end
				if (m_bvalid_o[m] && m_bready_i[m]) wr_order.push_back(m);
				if (m_rvalid_o[m] && m_rready_i[m]) rd_order.push_back(m);
			end
		end
	end

	initial begin
		lfsr   = 32'h16e1abd6;
		errors = 0;
		err0   = 0;
		RST    = 1'b0;
		{m_awvalid_i, m_wvalid_i, m_bready_i, m_arvalid_i, m_rready_i} = '0;
		{m_awaddr_i, m_araddr_i, m_awprot_i, m_arprot_i, m_wdata_i, m_wstrb_i} = '0;
		{s_bvalid_i, s_rvalid_i, s_rdata_i} = '0;
		{s_awready_i, s_wready_i, s_arready_i} = '1;    // Slaves always accept
		{wr_pend, rd_pend} = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		RST = 1'b1;

		// Quiet outputs after reset
		repeat (2) @(negedge CLK);
		got = 64'({m_awready_o, m_wready_o, m_bvalid_o, m_arready_o, m_rvalid_o,
			s_awvalid_o, s_wvalid_o, s_bready_o, s_arvalid_o, s_rready_o});
		if (got != 64'd0) report_mismatch("valid/ready outputs", got, 64'd0);
		@(posedge CLK);
		#1;
		end_test(1, "reset state");

		err0 = errors;
		aw_seen = 0;
		wr_order.delete();
		for (int m = 0; m < NUM_MASTERS; m++) begin
			for (int s = 0; s < NUM_SLAVES; s++) begin
				draw_addr(s, addr);
				draw_bits(32, d);
				draw_bits(4, st);
				draw_bits(3, p);
				do_write(m, addr, d, st[3:0], p[2:0]);
			end
		end
		if (aw_seen != 10 || wr_order.size() != 10) report_error("write handshakes missing");
		end_test(2, "writes to every window");

		err0 = errors;
		ar_seen = 0;
		rd_order.delete();
		for (int m = 0; m < NUM_MASTERS; m++) begin
			for (int s = 0; s < NUM_SLAVES; s++) begin
				draw_addr(s, addr);
				draw_bits(3, p);
				do_read(m, addr, p[2:0], 0);
			end
		end
		if (ar_seen != 10 || rd_order.size() != 10) report_error("read handshakes missing");
		end_test(3, "reads from every window");

		// Both masters contend on both paths at once
		err0 = errors;
		wr_order.delete();
		rd_order.delete();
		for (int i = 0; i < 8; i++) begin
			draw_addr(i % NUM_SLAVES, fa[i]);
		end
		fork
			for (int i = 0; i < 8; i += 2) begin
				do_write(0, fa[i], ~fa[i], 4'hF, 3'd0);
			end
			for (int i = 1; i < 8; i += 2) begin
				do_write(1, fa[i], ~fa[i], 4'hF, 3'd0);
			end
			for (int i = 0; i < 8; i += 2) begin
				do_read(0, fa[i + 1], 3'd1, 0);
			end
			for (int i = 1; i < 8; i += 2) begin
				do_read(1, fa[i - 1], 3'd1, 0);
			end
		join
		if (wr_order.size() != 8 || rd_order.size() != 8) begin
			report_error("contending transactions did not all complete");
		end else begin
			for (int i = 1; i < 8; i++) begin
				if (wr_order[i] == wr_order[i - 1] || rd_order[i] == rd_order[i - 1]) begin
					report_error($sformatf("completion %0d went to the same master twice", i));
				end
			end
		end
		end_test(4, "round-robin fairness");

		err0 = errors;
		wr_order.delete();
		rd_order.delete();
		draw_addr(1, addr);
		draw_addr(3, fa[0]);
		fork
			do_write(0, addr, 32'hA5A5_5A5A, 4'h3, 3'd2);
			do_read(1, fa[0], 3'd5, 6);    // Read held off by rready
		join
		if (wr_order.size() != 1 || rd_order.size() != 1) begin
			report_error("concurrent read and write did not both complete");
		end
		end_test(5, "concurrent read and write");

		$display("Tests run %0d, errors %0d", NUM_TESTS, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tb.f
hw/axi_xbar_pkg.sv
hw/txn_grant_if.sv
hw/slave_addr_decode.sv
hw/master_arbiter.sv
hw/write_router.sv
hw/read_router.sv
hw/axi_lite_xbar.sv
bench/tb_axi_lite_xbar.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_axi_lite_xbar \
	-o tb_sim > sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
! grep -q "Simulation failed" sim.log
